//--- compile.f
+incdir+design
design/trace_pkg.sv
design/uart_tx.sv
design/hex_line_fmt.sv
design/trace_fifo.sv
design/addr_trace_top.sv
tests/addr_trace_chk.sv
tests/tb_addr_trace.sv

//--- run.sh
#!/bin/sh
# Build the address trace testbench with Verilator and run it.
# Exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  --top-module tb_addr_trace \
  -f compile.f \
  --Mdir obj_dir \
  -o tb_addr_trace
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_addr_trace
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

//--- tests/tb_addr_trace.sv
// Testbench for the address trace port
// Writes addresses over Wishbone, decodes trx_o and checks every line
// against a reference built from the hex line rule

`timescale 1ns/1ns
`default_nettype none

`include "trace_defs.svh"

module tb_addr_trace;

  localparam int NDIG = `TRACE_ADDR_W / 4;
  localparam int DIV = `TRACE_CLK_DIV;
  // 1 single, 16 digit sweep, 10 burst, 4 status
  localparam int N_WRITES = 31;
  localparam int WATCHDOG_NS = N_WRITES * 60 * DIV * 4 * 2;

  logic        wb_clk_i;
  logic        reset_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        trx_o;

  // Acked addresses waiting for their line
  logic [`TRACE_ADDR_W-1:0] sent_q[$];
  // Bytes decoded from the serial line
  logic [7:0]  rx_q[$];
  logic [31:0] lfsr_q;
  int          lines_sent;
  int          lines_done;
  string       test_name;

  addr_trace_top addr_trace_top_i (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .trx_o    (trx_o)
  );

  // 4 ns clock
  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // Galois right shift, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per address bit
  task automatic random_addr(output logic [`TRACE_ADDR_W-1:0] a);
    a = '0;
    for (int i = 0; i < `TRACE_ADDR_W; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      a = {a[`TRACE_ADDR_W-2:0], lfsr_q[0]};
    end
  endtask

  // Digits first, highest nibble in the top byte, then the terminator
  function automatic logic [8*(NDIG+1)-1:0] expected_line(
      input logic [`TRACE_ADDR_W-1:0] addr);
    logic [8*(NDIG+1)-1:0] line;
    logic [3:0] n;
    for (int d = 0; d < NDIG; d++) begin
      n = addr[`TRACE_ADDR_W-1-4*d -: 4];
      if (n < 4'd10) begin
        line[8*(NDIG+1)-1-8*d -: 8] = 8'h30 + 8'(n);
      end else begin
        line[8*(NDIG+1)-1-8*d -: 8] = 8'h61 + 8'(n - 4'd10);
      end
    end
    line[7:0] = `TRACE_EOL;
    return line;
  endfunction

  // Write one address, held reports an ack withheld past the first cycle
  task automatic wb_write(input logic [`TRACE_ADDR_W-1:0] addr, output bit held);
    int waits;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_dat_i = {{(32-`TRACE_ADDR_W){1'b0}}, addr};
    waits = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      waits++;
    end while (!wb_ack_o);
    sent_q.push_back(addr);
    lines_sent++;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    held = (waits > 1);
    // One idle cycle so the ack register clears
    @(posedge wb_clk_i);
    #1;
  endtask

  task automatic wb_read(output trace_pkg::trace_status_t st);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    do begin
      @(posedge wb_clk_i);
      #1;
    end while (!wb_ack_o);
    st = trace_pkg::trace_status_t'(wb_dat_o);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    @(posedge wb_clk_i);
    #1;
  endtask

  task automatic wait_drain();
    while (lines_done != lines_sent) begin
      @(negedge wb_clk_i);
    end
    // Rest of the stop bit and the formatter's final step
    repeat (2 * DIV) @(posedge wb_clk_i);
    #1;
  endtask

  // Serial receiver, samples mid-bit on the falling clock
  initial begin
    logic [7:0] b;
    @(negedge reset_i);
    forever begin
      @(negedge trx_o);
      repeat (DIV / 2) @(negedge wb_clk_i);
      if (trx_o !== 1'b0) begin
        fail_now("start bit on trx_o did not last to mid-bit");
      end
      for (int i = 0; i < 8; i++) begin
        repeat (DIV) @(negedge wb_clk_i);
        b[i] = trx_o;
      end
      repeat (DIV) @(negedge wb_clk_i);
      if (trx_o !== 1'b1) begin
        fail_now("stop bit missing on trx_o");
      end
      rx_q.push_back(b);
    end
  end

  // Compare each received byte against the reference line
  initial begin
    logic [`TRACE_ADDR_W-1:0] a;
    logic [8*(NDIG+1)-1:0] line;
    logic [7:0] got;
    int pos;
    pos = 0;
    forever begin
      while (rx_q.size() == 0) begin
        @(negedge wb_clk_i);
      end
      got = rx_q.pop_front();
      if (pos == 0) begin
        if (sent_q.size() == 0) begin
          fail_now("serial byte arrived with no address written");
        end
        a = sent_q.pop_front();
        line = expected_line(a);
      end
      check_eq(test_name, 32'(line[8*(NDIG+1)-1-8*pos -: 8]), 32'(got));
      pos++;
      if (pos == NDIG + 1) begin
        pos = 0;
        lines_done++;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_now("watchdog expired, lines still missing");
  end

  initial begin
    trace_pkg::trace_status_t st;
    logic [`TRACE_ADDR_W-1:0] a;
    bit held;
    bit held_any;
    reset_i    = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_dat_i   = '0;
    lfsr_q     = 32'hc1d55601;
    lines_sent = 0;
    lines_done = 0;
    test_name  = "reset";
    repeat (5) @(posedge wb_clk_i);
    #1;
    reset_i = 1'b0;

    // Quiet bus, line idle
    test_name = "idle";
    repeat (20) begin
      @(negedge wb_clk_i);
      check_eq("idle_trx", 32'd1, 32'(trx_o));
      check_eq("idle_ack", 32'd0, 32'(wb_ack_o));
    end
    @(posedge wb_clk_i);
    #1;
    wb_read(st);
    check_eq("idle_count", 32'd0, 32'(st.count));
    check_eq("idle_busy", 32'd0, 32'(st.busy));
    check_eq("idle_upper_zero", 32'd0, 32'(st.zero));

    test_name = "single_12ab9";
    wb_write(20'h12ab9, held);
    wait_drain();

    // Each position sees every nibble value once
    test_name = "digit_sweep";
    for (int v = 0; v < 16; v++) begin
      a = {4'(v), 4'(v + 1), 4'(v + 2), 4'(v + 3), 4'(v + 4)};
      wb_write(a, held);
    end
    wait_drain();

    test_name = "random_burst";
    held_any = 1'b0;
    repeat (10) begin
      random_addr(a);
      wb_write(a, held);
      held_any |= held;
    end
    check_eq("burst_backpressure", 32'd1, 32'(held_any));
    wait_drain();

    // Three queued behind an active line
    test_name = "status";
    for (int k = 0; k < 4; k++) begin
      random_addr(a);
      wb_write(a, held);
    end
    wb_read(st);
    check_eq("status_busy", 32'd1, 32'(st.busy));
    check_eq("status_count_range", 32'd1, 32'(st.count >= 4'd1 && st.count <= 4'd3));
    wait_drain();
    wb_read(st);
    check_eq("drained_count", 32'd0, 32'(st.count));
    check_eq("drained_busy", 32'd0, 32'(st.busy));

    if (lines_done == lines_sent && rx_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_now("serial bytes left over after the last line");
    end
  end

endmodule

`default_nettype wire

//--- tests/addr_trace_chk.sv
// Concurrent checks on the trace port's Wishbone ack and serial idle level
// Attached to addr_trace_top through the bind at the end of this file

`timescale 1ns/1ns
`default_nettype none

module addr_trace_chk (
  input wire logic wb_clk_i,
  input wire logic reset_i,
  input wire logic wb_cyc_i,
  input wire logic wb_stb_i,
  input wire logic wb_ack_i,
  input wire logic tx_busy_i,
  input wire logic trx_i
);

  // Ack is a one-cycle pulse
  a_ack_pulse: assert property (
    @(posedge wb_clk_i) disable iff (reset_i)
    wb_ack_i |=> !wb_ack_i
  ) else $error("wb_ack_o high on two cycles in a row");

  // Every ack answers a request seen the cycle before
  a_ack_req: assert property (
    @(posedge wb_clk_i) disable iff (reset_i)
    wb_ack_i |-> $past(wb_cyc_i && wb_stb_i)
  ) else $error("wb_ack_o without a request in the prior cycle");

  // Stop bit already at mark level in the last busy cycle
  a_idle_mark: assert property (
    @(posedge wb_clk_i) disable iff (reset_i)
    $fell(tx_busy_i) |-> $past(trx_i)
  ) else $error("trx_o low in the last cycle before the transmitter went idle");

endmodule

bind addr_trace_top addr_trace_chk addr_trace_chk_i (
  .wb_clk_i  (wb_clk_i),
  .reset_i   (reset_i),
  .wb_cyc_i  (wb_cyc_i),
  .wb_stb_i  (wb_stb_i),
  .wb_ack_i  (wb_ack_o),
  .tx_busy_i (tx_busy),
  .trx_i     (trx_o)
);

`default_nettype wire

//--- design/addr_trace_top.sv
// Address trace port, a Wishbone slave printing each written address as hex
// Writes queue an address, reads return the trace_pkg status word

`timescale 1ns/1ns
`default_nettype none

`include "trace_defs.svh"

module addr_trace_top (
  input  wire logic        wb_clk_i,
  input  wire logic        reset_i,
  input  wire logic        wb_cyc_i,
  input  wire logic        wb_stb_i,
  input  wire logic        wb_we_i,
  input  wire logic [31:0] wb_dat_i,
  output logic [31:0]      wb_dat_o,
  output logic             wb_ack_o,
  output logic             trx_o
);

  trace_pkg::trace_addr_u  wr_word;
  trace_pkg::trace_addr_u  head_word;
  trace_pkg::trace_status_t status;
  logic        req;
  logic        wr_en;
  logic        rd_hit;
  logic        ack_q;
  logic [31:0] dat_q;
  logic        fifo_full;
  logic        fifo_valid;
  logic [3:0]  fifo_count;
  logic        fmt_ready;
  logic        fmt_busy;
  logic        tx_start;
  logic [7:0]  tx_byte;
  logic        tx_busy;

  assign req     = wb_cyc_i & wb_stb_i;
  // Ack cycle blocks a second push for the same request
  assign wr_en   = req & wb_we_i & ~ack_q & ~fifo_full;
  assign rd_hit  = req & ~wb_we_i & ~ack_q;
  // Only the low address bits are traced
  assign wr_word.flat = wb_dat_i[`TRACE_ADDR_W-1:0];

  // Status word
  always_comb begin
    status       = '0;
    status.count = fifo_count;
    status.busy  = fmt_busy | tx_busy;
  end

  // Ack one cycle after the request, withheld while full
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wr_en | rd_hit;
    end
  end

  // Read data sampled with the ack
  always_ff @(posedge wb_clk_i) begin
    if (rd_hit) begin
      dat_q <= status;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

  trace_fifo trace_fifo_i (
    .wb_clk_i   (wb_clk_i),
    .reset_i    (reset_i),
    .wr_en_i    (wr_en),
    .wr_data_i  (wr_word),
    .rd_ready_i (fmt_ready),
    .full_o     (fifo_full),
    .rd_valid_o (fifo_valid),
    .rd_data_o  (head_word),
    .count_o    (fifo_count)
  );

  hex_line_fmt hex_line_fmt_i (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .addr_valid_i (fifo_valid),
    .addr_i       (head_word),
    .tx_busy_i    (tx_busy),
    .addr_ready_o (fmt_ready),
    .tx_start_o   (tx_start),
    .tx_byte_o    (tx_byte),
    .busy_o       (fmt_busy)
  );

  uart_tx uart_tx_i (
    .wb_clk_i   (wb_clk_i),
    .reset_i    (reset_i),
    .tx_start_i (tx_start),
    .tx_byte_i  (tx_byte),
    .tx_busy_o  (tx_busy),
    .trx_o      (trx_o)
  );

endmodule

`default_nettype wire

//--- design/trace_fifo.sv
// Synchronous FIFO for pending trace addresses
// Head word valid one cycle after the write, push and pop may coincide

`timescale 1ns/1ns
`default_nettype none

`include "trace_defs.svh"

module trace_fifo (
  input  wire logic                   wb_clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   wr_en_i,
  input  wire trace_pkg::trace_addr_u wr_data_i,
  input  wire logic                   rd_ready_i,
  output logic                        full_o,
  output logic                        rd_valid_o,
  output trace_pkg::trace_addr_u      rd_data_o,
  output logic [3:0]                  count_o
);

  localparam int DEPTH = `TRACE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  trace_pkg::trace_addr_u mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [3:0]       count_q;
  logic             push;
  logic             pop;

  assign full_o     = (count_q == 4'(DEPTH));
  assign rd_valid_o = (count_q != 4'd0);
  // Writes into a full queue are dropped
  assign push       = wr_en_i & ~full_o;
  assign pop        = rd_valid_o & rd_ready_i;

  // Storage
  always_ff @(posedge wb_clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  // Pointers wrap at the power-of-two depth
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Occupancy unchanged when both happen
      if (push && !pop) begin
        count_q <= count_q + 4'd1;
      end else if (pop && !push) begin
        count_q <= count_q - 4'd1;
      end
    end
  end

  assign rd_data_o = mem[rd_ptr_q];
  assign count_o   = count_q;

endmodule

`default_nettype wire

//--- design/hex_line_fmt.sv
// Turns one queued address into a text line of hex digits and a terminator
// Takes a word on addr_valid_i/addr_ready_o, feeds bytes to the transmitter

`timescale 1ns/1ns
`default_nettype none

`include "trace_defs.svh"

module hex_line_fmt (
  input  wire logic                 wb_clk_i,
  input  wire logic                 reset_i,
  input  wire logic                 addr_valid_i,
  input  wire trace_pkg::trace_addr_u addr_i,
  input  wire logic                 tx_busy_i,
  output logic                      addr_ready_o,
  output logic                      tx_start_o,
  output logic [7:0]                tx_byte_o,
  output logic                      busy_o
);

  // Hex digits per line, one extra position for the terminator
  localparam int NIBS  = `TRACE_ADDR_W / 4;
  localparam int POS_W = NIBS + 1;

  trace_pkg::trace_addr_u addr_q;
  // One-hot character position, all zero when idle
  logic [POS_W-1:0] pos_q;
  // Byte of the current position handed to the transmitter
  logic             sent_q;
  logic             tx_start_q;
  logic [7:0]       tx_byte_q;
  logic [7:0]       char;
  logic             accept;
  logic             issue;
  logic             done;

  // 0-9 to '0'-'9', 10-15 to 'a'-'f'
  function automatic logic [7:0] hex_ascii(input logic [3:0] n);
    if (n <= 4'd9) begin
      return 8'h30 + {4'h0, n};
    end
    return 8'h57 + {4'h0, n};
  endfunction

  assign busy_o       = |pos_q;
  assign addr_ready_o = ~busy_o;
  assign accept       = addr_valid_i & addr_ready_o;
  // Transmitter free and nothing outstanding for this position
  assign issue        = busy_o & ~sent_q & ~tx_busy_i;
  // Our byte has gone through busy and the stop bit finished
  assign done         = busy_o & sent_q & ~tx_start_q & ~tx_busy_i;

  // Character for the active position, highest nibble first
  always_comb begin
    char = `TRACE_EOL;
    for (int i = 0; i < NIBS; i++) begin
      if (pos_q[i]) begin
        char = hex_ascii(addr_q.nib[NIBS-1-i]);
      end
    end
  end

  // Position walk and start pulse
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      pos_q      <= '0;
      sent_q     <= 1'b0;
      tx_start_q <= 1'b0;
    end else begin
      tx_start_q <= issue;
      if (accept) begin
        pos_q  <= POS_W'(1);
        sent_q <= 1'b0;
      end else if (issue) begin
        sent_q <= 1'b1;
      end else if (done) begin
        // Shifting past the terminator returns to idle
        pos_q  <= pos_q << 1;
        sent_q <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      addr_q <= addr_i;
    end
    if (issue) begin
      tx_byte_q <= char;
    end
  end

  assign tx_start_o = tx_start_q;
  assign tx_byte_o  = tx_byte_q;

endmodule

`default_nettype wire

//--- design/uart_tx.sv
// Byte-wide 8N1 serial transmitter
// Pulse tx_start_i while tx_busy_o is low, the frame leaves LSB first

`timescale 1ns/1ns
`default_nettype none

`include "trace_defs.svh"

module uart_tx (
  input  wire logic       wb_clk_i,
  input  wire logic       reset_i,
  input  wire logic       tx_start_i,
  input  wire logic [7:0] tx_byte_i,
  output logic            tx_busy_o,
  output logic            trx_o
);

  // Divider counter sized to hold the full bit period
  localparam int DIV_W = $clog2(`TRACE_CLK_DIV + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`TRACE_CLK_DIV - 1);

  // Start bit, eight data bits, stop bit
  logic [9:0]       frame_q;
  logic [DIV_W-1:0] div_q;
  logic [3:0]       bit_q;
  logic             busy_q;
  logic             load;
  logic             bit_end;

  // New frame only accepted while the line is idle
  assign load    = tx_start_i & ~busy_q;
  // Last cycle of the current bit period
  assign bit_end = busy_q & (div_q == DIV_LAST);

  // Control state
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      div_q  <= '0;
      bit_q  <= '0;
    end else if (load) begin
      busy_q <= 1'b1;
      div_q  <= '0;
      bit_q  <= '0;
    end else if (busy_q) begin
      if (bit_end) begin
        div_q <= '0;
        bit_q <= bit_q + 4'd1;
        // Stop bit done, back to idle
        if (bit_q == 4'd9) begin
          busy_q <= 1'b0;
        end
      end else begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  // Shift frame, ones shifted in behind the stop bit
  always_ff @(posedge wb_clk_i) begin
    if (load) begin
      frame_q <= {1'b1, tx_byte_i, 1'b0};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

  assign tx_busy_o = busy_q;
  // Line held at mark level while idle
  assign trx_o     = frame_q[0] | ~busy_q;

endmodule

`default_nettype wire

//--- design/trace_pkg.sv
// Shared types of the address trace port
// Referenced by scoped name from the RTL and the testbench

`default_nettype none

`include "trace_defs.svh"

package trace_pkg;

  // One address word
  // Bus and FIFO use the flat view, the formatter picks digits
  typedef union packed {
    logic [`TRACE_ADDR_W-1:0]          flat;
    logic [`TRACE_ADDR_W/4-1:0][3:0]   nib;
  } trace_addr_u;

  // Status word returned on a Wishbone read
  typedef struct packed {
    // Always zero
    logic [26:0] zero;
    // Formatter or transmitter still working
    logic        busy;
    // Addresses waiting in the FIFO
    logic [3:0]  count;
  } trace_status_t;

endpackage

`default_nettype wire

//--- design/trace_defs.svh
// Build-time constants for the address trace port
// Included by the package and by every module that sizes logic from them

`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

// Physical address width written by the CPU
// Must be a multiple of 4 so the word splits into hex digits
`define TRACE_ADDR_W 20

// Queued addresses in front of the formatter
// Power of two, pointers wrap naturally
`define TRACE_FIFO_DEPTH 4

// wb_clk_i cycles per serial bit
`define TRACE_CLK_DIV 8

// Byte sent after the last hex digit of a line
`define TRACE_EOL 8'h0a

`endif
